// File: compile.f
design/csr_addr_pkg.sv
design/csr_op_pkg.sv
design/csr_wr_if.sv
design/csr_ctrl.sv
design/csr_status_regs.sv
design/csr_trap_regs.sv
design/csr_read_mux.sv
design/csr_unit.sv
verif/csr_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module csr_unit_tb \
    -Mdir obj_dir -o csr_unit_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build returned status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/csr_unit_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: verif/csr_unit_input.txt
# op addr wdata cause epc tval | exp_rdata exp_illegal exp_trap_pc exp_ret_pc
# op codes: 1 rw, 2 rs, 3 rc, 4 trap, 5 mret; all fields in hex
2 300 00000000 00000000 00000000 00000000 00001800 0 00000000 00000000
2 341 00000000 00000000 00000000 00000000 00000000 0 00000000 00000000
2 342 00000000 00000000 00000000 00000000 00000000 0 00000000 00000000
2 f11 00000000 00000000 00000000 00000000 00000000 1 00000000 00000000
2 301 00000000 00000000 00000000 00000000 00000000 1 00000000 00000000
2 306 00000000 00000000 00000000 00000000 00000000 1 00000000 00000000
1 340 a5a50f0f 00000000 00000000 00000000 00000000 0 00000000 00000000
2 340 0000f0f0 00000000 00000000 00000000 a5a50f0f 0 00000000 00000000
3 340 a50000ff 00000000 00000000 00000000 a5a5ffff 0 00000000 00000000
2 340 00000000 00000000 00000000 00000000 00a5ff00 0 00000000 00000000
1 304 ffffffff 00000000 00000000 00000000 00000000 0 00000000 00000000
2 304 00000000 00000000 00000000 00000000 00000888 0 00000000 00000000
1 344 ffffffff 00000000 00000000 00000000 00000000 0 00000000 00000000
2 344 00000000 00000000 00000000 00000000 00000888 0 00000000 00000000
1 305 00001003 00000000 00000000 00000000 00000000 0 00001000 00000000
2 305 00000000 00000000 00000000 00000000 00001000 0 00001000 00000000
1 f14 ffffffff 00000000 00000000 00000000 00000000 1 00001000 00000000
1 301 00000000 00000000 00000000 00000000 00000000 1 00001000 00000000
1 7c0 00001234 00000000 00000000 00000000 00000000 1 00001000 00000000
2 7c0 00000000 00000000 00000000 00000000 00000000 1 00001000 00000000
2 300 00000008 00000000 00000000 00000000 00001800 0 00001000 00000000
4 000 00000000 0000000b 00002006 deadbeef 00000000 0 00001000 00002004
2 342 00000000 00000000 00000000 00000000 0000000b 0 00001000 00002004
2 343 00000000 00000000 00000000 00000000 deadbeef 0 00001000 00002004
2 300 00000000 00000000 00000000 00000000 00001880 0 00001000 00002004
5 000 00000000 00000000 00000000 00000000 00000000 0 00001000 00002004
2 300 00000000 00000000 00000000 00000000 00001888 0 00001000 00002004
2 341 00000000 00000000 00000000 00000000 00002004 0 00001000 00002004

// File: verif/csr_unit_tb.sv
module csr_unit_tb;

    logic                    clk;
    logic                    arst_n;
    logic                    op_valid;
    csr_op_pkg::csr_op_e     op;
    csr_addr_pkg::csr_addr_t addr;
    csr_op_pkg::data_t       wdata;
    csr_op_pkg::data_t       cause;
    csr_op_pkg::data_t       epc;
    csr_op_pkg::data_t       tval;
    csr_op_pkg::data_t       rdata;
    logic                    done;
    logic                    illegal;
    logic                    busy;
    csr_op_pkg::data_t       trap_pc;
    csr_op_pkg::data_t       ret_pc;

    int          test_count;
    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          fd;
    int          rc;
    int          fields;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_cause;
    logic [31:0] f_epc;
    logic [31:0] f_tval;
    logic [31:0] f_rdata;
    logic [31:0] f_illegal;
    logic [31:0] f_trap_pc;
    logic [31:0] f_ret_pc;

    csr_unit i_dut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .cause    (cause),
        .epc      (epc),
        .tval     (tval),
        .rdata    (rdata),
        .done     (done),
        .illegal  (illegal),
        .busy     (busy),
        .trap_pc  (trap_pc),
        .ret_pc   (ret_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_data(input string name, input csr_op_pkg::data_t got,
                              input csr_op_pkg::data_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] test %0d %s: got %08h, expected %08h", test_count, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] test %0d %s: got %0h, expected %0h", test_count, name, got, exp);
            test_errors++;
        end
    endtask

    // One operation: pulse, wait for done, then check result and targets
    task automatic apply_and_check(input logic [2:0] op_code, input csr_addr_pkg::csr_addr_t a,
                                   input csr_op_pkg::data_t wd, input csr_op_pkg::data_t c,
                                   input csr_op_pkg::data_t e, input csr_op_pkg::data_t t,
                                   input csr_op_pkg::data_t exp_rdata, input logic exp_illegal,
                                   input csr_op_pkg::data_t exp_trap_pc,
                                   input csr_op_pkg::data_t exp_ret_pc);
        int waited;
        @(posedge clk);
        #5;
        op       = csr_op_pkg::csr_op_e'(op_code);
        addr     = a;
        wdata    = wd;
        cause    = c;
        epc      = e;
        tval     = t;
        op_valid = 1'b1;
        @(posedge clk);
        #5;
        op_valid = 1'b0;
        waited   = 0;
        @(negedge clk);
        while (!done && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            $display("test %0d: no done pulse within 20 cycles of the request", test_count);
            test_errors++;
        end
        else
        begin
            check_data("rdata", rdata, exp_rdata);
            check_flag("illegal", illegal, exp_illegal);
            check_flag("busy", busy, 1'b1);
            // Strobes drop and targets settle one cycle after done
            @(negedge clk);
            check_flag("done", done, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_data("trap_pc", trap_pc, exp_trap_pc);
            check_data("ret_pc", ret_pc, exp_ret_pc);
        end
    endtask

    initial
    begin
        arst_n     = 1'b0;
        op_valid   = 1'b0;
        op         = csr_op_pkg::op_none;
        addr       = '0;
        wdata      = '0;
        cause      = '0;
        epc        = '0;
        tval       = '0;
        test_count = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (10) @(posedge clk);
        #5;
        arst_n = 1'b1;

        fd = $fopen("verif/csr_unit_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file verif/csr_unit_input.txt");
            $display("Test failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc   = $fgets(line, fd);
                // Skip blank and comment lines
                if (rc > 0 && line.len() > 1 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_addr,
                                     f_wdata, f_cause, f_epc, f_tval, f_rdata, f_illegal,
                                     f_trap_pc, f_ret_pc);
                    test_count++;
                    test_errors = 0;
                    if (fields != 10)
                    begin
                        $display("test %0d: stimulus line has %0d fields instead of 10",
                                 test_count, fields);
                        test_errors++;
                    end
                    else
                    begin
                        apply_and_check(f_op[2:0], f_addr[11:0], f_wdata, f_cause, f_epc,
                                        f_tval, f_rdata, f_illegal[0], f_trap_pc, f_ret_pc);
                    end
                    if (test_errors == 0)
                    begin
                        pass_count++;
                        $display("test %0d: op %0h addr %03h PASS", test_count, f_op[2:0],
                                 f_addr[11:0]);
                    end
                    else
                    begin
                        fail_count++;
                        $display("test %0d: op %0h addr %03h FAIL", test_count, f_op[2:0],
                                 f_addr[11:0]);
                    end
                end
            end
            $fclose(fd);

            $display("%0d tests run, %0d passed, %0d with errors", test_count, pass_count,
                     fail_count);
            if (fail_count == 0 && test_count > 0)
            begin
                $display("Test completed successfully");
            end
            else
            begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// File: design/csr_unit.sv
module csr_unit
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    op_valid,
    input  csr_op_pkg::csr_op_e     op,
    input  csr_addr_pkg::csr_addr_t addr,
    input  csr_op_pkg::data_t       wdata,
    input  csr_op_pkg::data_t       cause,
    input  csr_op_pkg::data_t       epc,
    input  csr_op_pkg::data_t       tval,
    output csr_op_pkg::data_t       rdata,
    output logic                    done,
    output logic                    illegal,
    output logic                    busy,
    output csr_op_pkg::data_t       trap_pc,
    output csr_op_pkg::data_t       ret_pc
);

    csr_addr_pkg::csr_addr_t raddr;
    csr_op_pkg::data_t       rvalue;
    logic                    raddr_valid;
    csr_op_pkg::data_t       mstatus;
    csr_op_pkg::data_t       mie;
    csr_op_pkg::data_t       mip;
    csr_op_pkg::data_t       mtvec;
    csr_op_pkg::data_t       mscratch;
    csr_op_pkg::data_t       mepc;
    csr_op_pkg::data_t       mcause;
    csr_op_pkg::data_t       mtval;

    csr_wr_if i_wr_if ();

    csr_ctrl i_ctrl
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .op_valid    (op_valid),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .cause       (cause),
        .epc         (epc),
        .tval        (tval),
        .rvalue      (rvalue),
        .raddr_valid (raddr_valid),
        .raddr       (raddr),
        .rdata       (rdata),
        .done        (done),
        .illegal     (illegal),
        .busy        (busy),
        .wr          (i_wr_if.ctrl)
    );

    csr_status_regs i_status_regs
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (i_wr_if.bank),
        .mstatus (mstatus),
        .mie     (mie),
        .mip     (mip)
    );

    csr_trap_regs i_trap_regs
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (i_wr_if.bank),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval)
    );

    csr_read_mux i_read_mux
    (
        .raddr       (raddr),
        .mstatus     (mstatus),
        .mie         (mie),
        .mip         (mip),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval),
        .rvalue      (rvalue),
        .raddr_valid (raddr_valid)
    );

    // Trap and return targets as levels
    assign trap_pc = mtvec;
    assign ret_pc  = mepc;

endmodule

// File: design/csr_read_mux.sv
module csr_read_mux
(
    input  csr_addr_pkg::csr_addr_t raddr,
    input  csr_op_pkg::data_t       mstatus,
    input  csr_op_pkg::data_t       mie,
    input  csr_op_pkg::data_t       mip,
    input  csr_op_pkg::data_t       mtvec,
    input  csr_op_pkg::data_t       mscratch,
    input  csr_op_pkg::data_t       mepc,
    input  csr_op_pkg::data_t       mcause,
    input  csr_op_pkg::data_t       mtval,
    output csr_op_pkg::data_t       rvalue,
    output logic                    raddr_valid
);

    always_comb
    begin
        raddr_valid = 1'b1;
        case (raddr)
            // Information registers are constants
            csr_addr_pkg::mvendorid_addr:  rvalue = csr_addr_pkg::mvendorid_value;
            csr_addr_pkg::marchid_addr:    rvalue = csr_addr_pkg::marchid_value;
            csr_addr_pkg::mimpid_addr:     rvalue = csr_addr_pkg::mimpid_value;
            csr_addr_pkg::mhartid_addr:    rvalue = csr_addr_pkg::mhartid_value;
            csr_addr_pkg::misa_addr:       rvalue = csr_addr_pkg::misa_value;
            csr_addr_pkg::mcounteren_addr: rvalue = csr_addr_pkg::mcounteren_value;

            // Status bank
            csr_addr_pkg::mstatus_addr:    rvalue = mstatus;
            csr_addr_pkg::mie_addr:        rvalue = mie;
            csr_addr_pkg::mip_addr:        rvalue = mip;

            // Trap bank
            csr_addr_pkg::mtvec_addr:      rvalue = mtvec;
            csr_addr_pkg::mscratch_addr:   rvalue = mscratch;
            csr_addr_pkg::mepc_addr:       rvalue = mepc;
            csr_addr_pkg::mcause_addr:     rvalue = mcause;
            csr_addr_pkg::mtval_addr:      rvalue = mtval;

            default:
            begin
                rvalue      = '0;
                raddr_valid = 1'b0;
            end
        endcase
    end

endmodule

// File: design/csr_trap_regs.sv
module csr_trap_regs
(
    input  logic              clk,
    input  logic              arst_n,
    csr_wr_if.bank            wr,
    output csr_op_pkg::data_t mtvec,
    output csr_op_pkg::data_t mscratch,
    output csr_op_pkg::data_t mepc,
    output csr_op_pkg::data_t mcause,
    output csr_op_pkg::data_t mtval
);

    csr_op_pkg::data_t mtvec_q;
    csr_op_pkg::data_t mscratch_q;
    csr_op_pkg::data_t mepc_q;
    csr_op_pkg::data_t mcause_q;
    csr_op_pkg::data_t mtval_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end
        else if (wr.trap_en)
        begin
            // Trap entry capture
            mepc_q   <= {wr.epc[31:2], 2'b00};
            mcause_q <= wr.cause;
            mtval_q  <= wr.tval;
        end
        else if (wr.wr_en)
        begin
            case (wr.waddr)
                // Direct mode only
                csr_addr_pkg::mtvec_addr:    mtvec_q    <= {wr.wdata[31:2], 2'b00};
                csr_addr_pkg::mscratch_addr: mscratch_q <= wr.wdata;
                csr_addr_pkg::mepc_addr:     mepc_q     <= {wr.wdata[31:2], 2'b00};
                csr_addr_pkg::mcause_addr:   mcause_q   <= wr.wdata;
                csr_addr_pkg::mtval_addr:    mtval_q    <= wr.wdata;
                default:
                begin
                end
            endcase
        end
    end

    assign mtvec    = mtvec_q;
    assign mscratch = mscratch_q;
    assign mepc     = mepc_q;
    assign mcause   = mcause_q;
    assign mtval    = mtval_q;

    // Return target stays word aligned
    a_mepc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n) mepc_q[1:0] == 2'b00
    );

endmodule

// File: design/csr_status_regs.sv
module csr_status_regs
(
    input  logic              clk,
    input  logic              arst_n,
    csr_wr_if.bank            wr,
    output csr_op_pkg::data_t mstatus,
    output csr_op_pkg::data_t mie,
    output csr_op_pkg::data_t mip
);

    logic              mie_bit_q;
    logic              mpie_bit_q;
    csr_op_pkg::data_t mie_q;
    csr_op_pkg::data_t mip_q;
    logic              wr_mstatus;
    logic              wr_mie;
    logic              wr_mip;

    assign wr_mstatus = wr.wr_en && (wr.waddr == csr_addr_pkg::mstatus_addr);
    assign wr_mie     = wr.wr_en && (wr.waddr == csr_addr_pkg::mie_addr);
    assign wr_mip     = wr.wr_en && (wr.waddr == csr_addr_pkg::mip_addr);

    // Interrupt enable stack
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mie_bit_q  <= 1'b0;
            mpie_bit_q <= 1'b0;
        end
        else if (wr.trap_en)
        begin
            mpie_bit_q <= mie_bit_q;
            mie_bit_q  <= 1'b0;
        end
        else if (wr.mret_en)
        begin
            mie_bit_q  <= mpie_bit_q;
            mpie_bit_q <= 1'b1;
        end
        else if (wr_mstatus)
        begin
            mie_bit_q  <= wr.wdata[csr_addr_pkg::mstatus_mie_bit];
            mpie_bit_q <= wr.wdata[csr_addr_pkg::mstatus_mpie_bit];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mie_q <= '0;
            mip_q <= '0;
        end
        else
        begin
            if (wr_mie)
            begin
                mie_q <= wr.wdata & csr_addr_pkg::mie_mask;
            end
            if (wr_mip)
            begin
                mip_q <= wr.wdata & csr_addr_pkg::mip_mask;
            end
        end
    end

    // MPP always reads as machine mode
    always_comb
    begin
        mstatus = '0;
        mstatus[csr_addr_pkg::mstatus_mie_bit]  = mie_bit_q;
        mstatus[csr_addr_pkg::mstatus_mpie_bit] = mpie_bit_q;
        mstatus[csr_addr_pkg::mstatus_mpp_lsb +: 2] = csr_addr_pkg::machine_mode;
    end

    assign mie = mie_q;
    assign mip = mip_q;

    a_trap_mret_exclusive : assert property (
        @(posedge clk) disable iff (!arst_n) !(wr.trap_en && wr.mret_en)
    );

endmodule

// File: design/csr_ctrl.sv
module csr_ctrl
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    op_valid,
    input  csr_op_pkg::csr_op_e     op,
    input  csr_addr_pkg::csr_addr_t addr,
    input  csr_op_pkg::data_t       wdata,
    input  csr_op_pkg::data_t       cause,
    input  csr_op_pkg::data_t       epc,
    input  csr_op_pkg::data_t       tval,
    input  csr_op_pkg::data_t       rvalue,
    input  logic                    raddr_valid,
    output csr_addr_pkg::csr_addr_t raddr,
    output csr_op_pkg::data_t       rdata,
    output logic                    done,
    output logic                    illegal,
    output logic                    busy,
    csr_wr_if.ctrl                  wr
);

    csr_op_pkg::ctrl_state_e state_q;
    csr_op_pkg::csr_op_e     op_q;
    csr_addr_pkg::csr_addr_t addr_q;
    csr_op_pkg::data_t       wdata_q;
    csr_op_pkg::data_t       cause_q;
    csr_op_pkg::data_t       epc_q;
    csr_op_pkg::data_t       tval_q;
    csr_op_pkg::data_t       new_value;
    logic                    exec;
    logic                    is_rmw;
    logic                    read_only;
    logic                    illegal_op;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= csr_op_pkg::st_idle;
            op_q    <= csr_op_pkg::op_none;
        end
        else
        begin
            case (state_q)
                csr_op_pkg::st_idle:
                begin
                    if (op_valid)
                    begin
                        state_q <= csr_op_pkg::st_exec;
                        op_q    <= op;
                    end
                end
                default:
                begin
                    state_q <= csr_op_pkg::st_idle;
                end
            endcase
        end
    end

    // Operands, held for the exec cycle
    always_ff @(posedge clk)
    begin
        if (op_valid && (state_q == csr_op_pkg::st_idle))
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            cause_q <= cause;
            epc_q   <= epc;
            tval_q  <= tval;
        end
    end

    assign exec  = (state_q == csr_op_pkg::st_exec);
    assign raddr = addr_q;

    assign is_rmw = (op_q == csr_op_pkg::op_rw) || (op_q == csr_op_pkg::op_rs) ||
                    (op_q == csr_op_pkg::op_rc);

    // F1x range plus misa and mcounteren cannot be written
    assign read_only = (addr_q[11:4] == csr_addr_pkg::info_addr_prefix) ||
                       (addr_q == csr_addr_pkg::misa_addr) ||
                       (addr_q == csr_addr_pkg::mcounteren_addr);

    assign illegal_op = is_rmw && (!raddr_valid || read_only);

    always_comb
    begin
        case (op_q)
            csr_op_pkg::op_rw: new_value = wdata_q;
            csr_op_pkg::op_rs: new_value = rvalue | wdata_q;
            csr_op_pkg::op_rc: new_value = rvalue & ~wdata_q;
            default:           new_value = rvalue;
        endcase
    end

    // Result strobe
    assign done    = exec;
    assign busy    = exec;
    assign illegal = exec && illegal_op;
    assign rdata   = (exec && is_rmw && !illegal_op) ? rvalue : '0;

    // Commands to the banks
    assign wr.waddr   = addr_q;
    assign wr.wdata   = new_value;
    assign wr.wr_en   = exec && is_rmw && !illegal_op;
    assign wr.trap_en = exec && (op_q == csr_op_pkg::op_trap);
    assign wr.mret_en = exec && (op_q == csr_op_pkg::op_mret);
    assign wr.cause   = cause_q;
    assign wr.epc     = epc_q;
    assign wr.tval    = tval_q;

    // Caller honours busy
    a_no_op_while_busy : assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !op_valid
    );

    // Fixed one-cycle latency from request to done
    a_done_after_op : assert property (
        @(posedge clk) disable iff (!arst_n) op_valid |=> done
    );

    a_done_only_after_op : assert property (
        @(posedge clk) disable iff (!arst_n) done |-> $past(op_valid)
    );

endmodule

// File: design/csr_wr_if.sv
interface csr_wr_if;

    csr_addr_pkg::csr_addr_t waddr;
    csr_op_pkg::data_t       wdata;
    logic                    wr_en;
    logic                    trap_en;
    logic                    mret_en;

    // Trap entry payload
    csr_op_pkg::data_t       cause;
    csr_op_pkg::data_t       epc;
    csr_op_pkg::data_t       tval;

    modport ctrl
    (
        output waddr, wdata, wr_en, trap_en, mret_en, cause, epc, tval
    );

    modport bank
    (
        input waddr, wdata, wr_en, trap_en, mret_en, cause, epc, tval
    );

endinterface

// File: design/csr_op_pkg.sv
package csr_op_pkg;

    typedef logic [31:0] data_t;

    // Operation requested by the pipeline
    typedef enum logic [2:0]
    {
        op_none = 3'd0,
        op_rw   = 3'd1,
        op_rs   = 3'd2,
        op_rc   = 3'd3,
        op_trap = 3'd4,
        op_mret = 3'd5
    } csr_op_e;

    // Controller sequencing
    typedef enum logic
    {
        st_idle = 1'b0,
        st_exec = 1'b1
    } ctrl_state_e;

endpackage

// File: design/csr_addr_pkg.sv
package csr_addr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine information registers
    localparam csr_addr_t mvendorid_addr  = 12'hf11;
    localparam csr_addr_t marchid_addr    = 12'hf12;
    localparam csr_addr_t mimpid_addr     = 12'hf13;
    localparam csr_addr_t mhartid_addr    = 12'hf14;

    // Machine trap setup
    localparam csr_addr_t mstatus_addr    = 12'h300;
    localparam csr_addr_t misa_addr       = 12'h301;
    localparam csr_addr_t mie_addr        = 12'h304;
    localparam csr_addr_t mtvec_addr      = 12'h305;
    localparam csr_addr_t mcounteren_addr = 12'h306;

    // Machine trap handling
    localparam csr_addr_t mscratch_addr   = 12'h340;
    localparam csr_addr_t mepc_addr       = 12'h341;
    localparam csr_addr_t mcause_addr     = 12'h342;
    localparam csr_addr_t mtval_addr      = 12'h343;
    localparam csr_addr_t mip_addr        = 12'h344;

    // Upper address bits shared by all F1x info registers
    localparam logic [7:0] info_addr_prefix = 8'hf1;

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;

    localparam logic [1:0] machine_mode = 2'b11;

    // Software, timer and external enables/pendings only
    localparam logic [31:0] mie_mask = 32'h0000_0888;
    localparam logic [31:0] mip_mask = 32'h0000_0888;

    // Read-only register contents
    localparam logic [31:0] misa_value       = 32'h4000_0100;
    localparam logic [31:0] mvendorid_value  = 32'h0000_0000;
    localparam logic [31:0] marchid_value    = 32'h0000_0000;
    localparam logic [31:0] mimpid_value     = 32'h0000_0001;
    localparam logic [31:0] mhartid_value    = 32'h0000_0000;
    localparam logic [31:0] mcounteren_value = 32'h0000_0000;

endpackage
